/* Makefile */
# Verilator build for the ULPI transmitter testbench

VERILATOR ?= verilator
TOP       ?= tb_ulpi_tx
RTL_TOP   ?= ulpi_tx_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint lint_rtl build sim clean

all: sim

# Lint the testbench together with the design
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Lint the synthesizable part alone
lint_rtl:
	$(VERILATOR) --lint-only ulpi_tx_pkg.sv usb_crc16.sv ulpi_skid_loader.sv \
		ulpi_encoder.sv ulpi_tx_top.sv --top-module $(RTL_TOP)

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the exit status
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src.f */
ulpi_tx_pkg.sv
usb_crc16.sv
ulpi_skid_loader.sv
ulpi_encoder.sv
ulpi_tx_top.sv
ulpi_tx_checker.sv
tb_ulpi_tx.sv

/* tb_ulpi_tx.sv */
`timescale 1ns/10ps
`default_nettype none

// Table-driven testbench for the ULPI transmitter
module tb_ulpi_tx
  import ulpi_tx_pkg::*;
;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_TESTS    = 10;
  // 40 cycles per entry, plus reset and the closing wait
  localparam int WATCHDOG_NS  = (NUM_TESTS * 40 + RESET_CYCLES + 16) * CLK_PERIOD;

  localparam logic [2:0] KIND_PKT   = 3'd0;
  localparam logic [2:0] KIND_HSK   = 3'd1;
  localparam logic [2:0] KIND_REGW  = 3'd2;
  localparam logic [2:0] KIND_NOPID = 3'd3;
  localparam logic [2:0] KIND_STOP  = 3'd4;

  // Done bits are {phy, hsk, usb}
  localparam logic [2:0] DONE_USB = 3'b001;
  localparam logic [2:0] DONE_HSK = 3'b010;
  localparam logic [2:0] DONE_PHY = 3'b100;

  typedef struct packed {
    logic [2:0] kind;
    pid_t       pid;
    byte_t      cmd0;
    byte_t      cmd1;
    logic [3:0] len;
    logic [2:0] done;
    logic       dir;
  } entry_t;

  entry_t      table_q [NUM_TESTS];
  entry_t      cur;
  logic [63:0] payload;
  logic        start;

  logic        clock;
  logic        reset;
  logic        high_speed;
  logic        s_valid;
  usb_beat_t   s_beat;
  pid_t        s_pid;
  logic        s_ready;
  logic        phy_write;
  logic        phy_nopid;
  logic        phy_stop;
  byte_t       phy_addr;
  byte_t       phy_data;
  logic        hsk_send;
  logic        ulpi_dir;
  logic        ulpi_nxt = 1'b0;
  logic        ulpi_stp;
  byte_t       ulpi_data;
  logic        encode_idle;
  logic        usb_busy;
  logic        usb_done;
  logic        phy_busy;
  logic        phy_done;
  logic        hsk_done;
  int          pass_count;
  int          fail_count;

  // PHY model state
  logic        nxt_next;
  int          low_run;
  logic [31:0] nxt_rnd;

  ulpi_tx_top UUT (
    .clock         (clock),
    .reset         (reset),
    .high_speed_i  (high_speed),
    .s_valid_i     (s_valid),
    .s_beat_i      (s_beat),
    .s_pid_i       (s_pid),
    .s_ready_o     (s_ready),
    .phy_write_i   (phy_write),
    .phy_nopid_i   (phy_nopid),
    .phy_stop_i    (phy_stop),
    .phy_addr_i    (phy_addr),
    .phy_data_i    (phy_data),
    .hsk_send_i    (hsk_send),
    .encode_idle_o (encode_idle),
    .usb_busy_o    (usb_busy),
    .usb_done_o    (usb_done),
    .phy_busy_o    (phy_busy),
    .phy_done_o    (phy_done),
    .hsk_done_o    (hsk_done),
    .ulpi_dir_i    (ulpi_dir),
    .ulpi_nxt_i    (ulpi_nxt),
    .ulpi_stp_o    (ulpi_stp),
    .ulpi_data_o   (ulpi_data)
  );

  ulpi_tx_checker u_checker (
    .clock         (clock),
    .reset         (reset),
    .start_i       (start),
    .kind_i        (cur.kind),
    .pid_i         (cur.pid),
    .cmd0_i        (cur.cmd0),
    .cmd1_i        (cur.cmd1),
    .len_i         (cur.len),
    .payload_i     (payload),
    .done_exp_i    (cur.done),
    .ulpi_dir_i    (ulpi_dir),
    .ulpi_nxt_i    (ulpi_nxt),
    .ulpi_stp_i    (ulpi_stp),
    .ulpi_data_i   (ulpi_data),
    .head_valid_i  (UUT.head_valid),
    .encode_idle_i (encode_idle),
    .usb_busy_i    (usb_busy),
    .phy_busy_i    (phy_busy),
    .usb_done_i    (usb_done),
    .hsk_done_i    (hsk_done),
    .phy_done_i    (phy_done),
    .pass_count_o  (pass_count),
    .fail_count_o  (fail_count)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // PHY model, NXT decided on the rising edge and driven on the falling edge
  // Never more than three low cycles in a row, held high during NOPID
  always @(posedge clock) begin
    nxt_rnd = $urandom;
    if (reset || ulpi_dir) begin
      nxt_next = 1'b0;
      low_run  = 0;
    end else if (phy_nopid || low_run >= 3) begin
      nxt_next = 1'b1;
      low_run  = 0;
    end else begin
      nxt_next = nxt_rnd[0];
      low_run  = nxt_next ? 0 : low_run + 1;
    end
  end

  always @(negedge clock) begin
    ulpi_nxt <= nxt_next;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout, a test never finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic make_payload();
    logic [31:0] rnd;
    for (int i = 0; i < 8; i++) begin
      rnd = $urandom;
      payload[8*i +: 8] = rnd[7:0];
    end
  endtask

  // Levels for the current entry
  task automatic apply_request();
    high_speed = (cur.kind == KIND_PKT) || (cur.kind == KIND_HSK);
    s_pid      = cur.pid;
    hsk_send   = (cur.kind == KIND_HSK);
    phy_write  = (cur.kind == KIND_REGW);
    phy_nopid  = (cur.kind == KIND_NOPID);
    phy_stop   = (cur.kind == KIND_STOP);
    phy_addr   = cur.cmd0;
    phy_data   = cur.cmd1;
  endtask

  task automatic clear_requests();
    hsk_send  = 1'b0;
    phy_write = 1'b0;
    phy_nopid = 1'b0;
    phy_stop  = 1'b0;
  endtask

  // Stream the payload, a lone keep-low beat for a zero-length packet
  task automatic send_stream(input int len);
    int   idx;
    int   nbeats;
    logic fired;
    idx = 0;
    nbeats = (len == 0) ? 1 : len;
    while (idx < nbeats) begin
      s_valid     = 1'b1;
      s_beat.data = (len == 0) ? 8'h00 : payload[8*idx +: 8];
      s_beat.keep = (len != 0);
      s_beat.last = (idx == nbeats - 1);
      // Ready is stable between the falling edge and the next rising edge
      #1;
      fired = s_ready;
      @(negedge clock);
      if (fired) begin
        idx++;
      end
    end
    s_valid = 1'b0;
    s_beat  = '0;
  endtask

  task automatic wait_done();
    while (!(usb_done || hsk_done || phy_done)) begin
      @(negedge clock);
    end
  endtask

  initial begin
    logic [31:0] seed_r;
    seed_r = $urandom(1);
    reset = 1'b1;
    start = 1'b0;
    cur = '0;
    payload = '0;
    s_valid = 1'b0;
    s_beat = '0;
    ulpi_dir = 1'b0;
    high_speed = 1'b0;
    s_pid = '0;
    phy_addr = '0;
    phy_data = '0;
    clear_requests();
    // PHY setup first, then high-speed traffic
    table_q[0] = '{KIND_REGW,  4'h0, 8'h84, 8'h55, 4'd0, DONE_PHY, 1'b0};
    table_q[1] = '{KIND_NOPID, 4'h0, 8'h00, 8'h00, 4'd0, DONE_PHY, 1'b0};
    table_q[2] = '{KIND_STOP,  4'h0, 8'h00, 8'h00, 4'd0, DONE_PHY, 1'b0};
    table_q[3] = '{KIND_REGW,  4'h0, 8'h8A, 8'h0F, 4'd0, DONE_PHY, 1'b0};
    table_q[4] = '{KIND_PKT,   4'h3, 8'h00, 8'h00, 4'd8, DONE_USB, 1'b0};
    table_q[5] = '{KIND_PKT,   4'hB, 8'h00, 8'h00, 4'd0, DONE_USB, 1'b0};
    table_q[6] = '{KIND_HSK,   4'h2, 8'h00, 8'h00, 4'd0, DONE_HSK, 1'b1};
    table_q[7] = '{KIND_PKT,   4'hB, 8'h00, 8'h00, 4'd3, DONE_USB, 1'b0};
    table_q[8] = '{KIND_HSK,   4'hA, 8'h00, 8'h00, 4'd0, DONE_HSK, 1'b0};
    table_q[9] = '{KIND_PKT,   4'h3, 8'h00, 8'h00, 4'd1, DONE_USB, 1'b0};
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(negedge clock);
      cur = table_q[t];
      make_payload();
      apply_request();
      start = 1'b1;
      // PHY grabs the bus while the request is already up
      if (cur.dir) begin
        ulpi_dir = 1'b1;
      end
      @(negedge clock);
      start = 1'b0;
      if (cur.dir) begin
        repeat (2) @(negedge clock);
        ulpi_dir = 1'b0;
      end
      if (cur.kind == KIND_PKT) begin
        send_stream(int'(cur.len));
      end
      wait_done();
      clear_requests();
    end
    // Room for any stray done pulse
    repeat (10) @(negedge clock);
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count == NUM_TESTS) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ulpi_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

// ULPI transmit FSM
// Picks the source of every byte towards the skid loader
module ulpi_encoder
  import ulpi_tx_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  input  wire              high_speed_i,
  // Packet stream
  input  wire              s_valid_i,
  input  wire usb_beat_t   s_beat_i,
  input  wire pid_t        s_pid_i,
  output logic             s_ready_o,
  // PHY commands, level requests
  input  wire              phy_write_i,
  input  wire              phy_nopid_i,
  input  wire              phy_stop_i,
  input  wire byte_t       phy_addr_i,
  input  wire byte_t       phy_data_i,
  input  wire              hsk_send_i,
  input  wire              ulpi_dir_i,
  // Status
  output logic             encode_idle_o,
  output logic             usb_busy_o,
  output logic             usb_done_o,
  output logic             phy_busy_o,
  output logic             phy_done_o,
  output logic             hsk_done_o,
  // CRC unit
  input  wire crc16_t      crc_i,
  output logic             crc_clear_o,
  output logic             crc_step_o,
  output byte_t            crc_byte_o,
  // Skid loader
  input  wire              src_ready_i,
  input  wire              tmp_ready_i,
  input  wire              head_valid_i,
  input  wire              head_taken_i,
  input  wire              head_last_i,
  output logic             src_valid_o,
  output ulpi_beat_t       src_beat_o,
  output logic             tmp_valid_o,
  output ulpi_beat_t       tmp_beat_o
);

  tx_state_e state_q;
  tx_state_e state_d;

  logic  dir_q;
  logic  hold;
  // Kind of the running sequence, latched while idle
  logic  hsk_q;
  logic  phy_q;
  logic  nopid_q;
  // Blocks a level request that is still high after its done pulse
  logic  lock_q;
  logic  usb_done_q;
  logic  hsk_done_q;
  logic  phy_done_q;

  logic  src_fire;
  logic  s_fire;
  logic  done_evt;
  logic  nopid_done;
  logic  any_req;
  byte_t pid_cmd;

  // PHY owns the bus while DIR is high and for the turnaround cycle after
  assign hold    = ulpi_dir_i | dir_q;
  assign pid_cmd = TXCMD_NOPID | byte_t'(s_pid_i);
  assign any_req = hsk_send_i | phy_write_i | phy_nopid_i | phy_stop_i;

  assign src_fire = src_valid_o & src_ready_i;
  assign s_fire   = s_valid_i & s_ready_o;

  // Byte source mux
  always_comb begin
    s_ready_o   = 1'b0;
    src_valid_o = 1'b0;
    src_beat_o  = '0;
    tmp_valid_o = 1'b0;
    tmp_beat_o  = '0;
    if (!hold) begin
      case (state_q)
        TX_XPID: begin
          src_beat_o = '{data: pid_cmd, last: 1'b0};
          if (hsk_q) begin
            // PID and STP go in together, needs an empty buffer
            src_valid_o = tmp_ready_i;
            tmp_valid_o = tmp_ready_i;
            tmp_beat_o  = STOP_BEAT;
          end else begin
            src_valid_o = 1'b1;
          end
        end
        TX_DATA: begin
          // End marker is consumed without a byte
          s_ready_o   = src_ready_i;
          src_valid_o = s_valid_i & s_beat_i.keep;
          src_beat_o  = '{data: s_beat_i.data, last: 1'b0};
        end
        TX_CRC0: begin
          src_valid_o = 1'b1;
          src_beat_o  = '{data: crc_i[7:0], last: 1'b0};
        end
        TX_CRC1: begin
          src_valid_o = 1'b1;
          src_beat_o  = '{data: crc_i[15:8], last: 1'b0};
        end
        TX_LAST, TX_STOP: begin
          src_valid_o = 1'b1;
          src_beat_o  = STOP_BEAT;
        end
        TX_INIT: begin
          if (nopid_q) begin
            src_valid_o = 1'b1;
            src_beat_o  = '{data: TXCMD_NOPID, last: 1'b0};
          end else begin
            // Register address in head, value in temp
            src_valid_o = tmp_ready_i;
            src_beat_o  = '{data: phy_addr_i, last: 1'b0};
            tmp_valid_o = tmp_ready_i;
            tmp_beat_o  = '{data: phy_data_i, last: 1'b0};
          end
        end
        TX_REGW: begin
          // STP queued behind the register value, lands once temp frees
          src_valid_o = ~nopid_q;
          src_beat_o  = STOP_BEAT;
        end
        default: begin
        end
      endcase
    end
  end

  // Next state, frozen across DIR and turnaround
  always_comb begin
    state_d = state_q;
    if (!hold) begin
      case (state_q)
        TX_IDLE: begin
          // Start only with a drained skid buffer
          if (!head_valid_i && src_ready_i) begin
            if (high_speed_i) begin
              if ((hsk_send_i && !lock_q) || s_valid_i) begin
                state_d = TX_XPID;
              end
            end else if (!lock_q) begin
              if (phy_write_i || phy_nopid_i) begin
                state_d = TX_INIT;
              end else if (phy_stop_i) begin
                state_d = TX_STOP;
              end
            end
          end
        end
        TX_XPID: if (src_fire) state_d = hsk_q ? TX_DONE : TX_DATA;
        TX_DATA: begin
          if (s_fire && (!s_beat_i.keep || s_beat_i.last)) begin
            state_d = TX_CRC0;
          end
        end
        TX_CRC0: if (src_fire) state_d = TX_CRC1;
        TX_CRC1: if (src_fire) state_d = TX_LAST;
        TX_LAST: if (src_fire) state_d = TX_DONE;
        // Wait for the STP cycle itself
        TX_DONE: if (head_last_i) state_d = TX_IDLE;
        TX_INIT: if (src_fire) state_d = TX_REGW;
        TX_REGW: begin
          if (nopid_q) begin
            // NOPID ends once the PHY takes the command byte
            if (head_taken_i && src_ready_i) state_d = TX_IDLE;
          end else if (src_fire) begin
            state_d = TX_DONE;
          end
        end
        TX_STOP: if (src_fire) state_d = TX_DONE;
        default: state_d = TX_IDLE;
      endcase
    end
  end

  assign done_evt   = (state_q == TX_DONE) && (state_d == TX_IDLE);
  assign nopid_done = (state_q == TX_REGW) && nopid_q && (state_d == TX_IDLE);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= TX_IDLE;
      dir_q      <= 1'b0;
      hsk_q      <= 1'b0;
      phy_q      <= 1'b0;
      nopid_q    <= 1'b0;
      lock_q     <= 1'b0;
      usb_done_q <= 1'b0;
      hsk_done_q <= 1'b0;
      phy_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      dir_q   <= ulpi_dir_i;
      // Captured every idle cycle, the exit cycle wins
      if (state_q == TX_IDLE) begin
        hsk_q   <= high_speed_i & hsk_send_i & ~lock_q;
        phy_q   <= ~high_speed_i;
        nopid_q <= ~phy_write_i;
      end
      if (done_evt || nopid_done) begin
        lock_q <= 1'b1;
      end else if (!any_req) begin
        lock_q <= 1'b0;
      end
      usb_done_q <= done_evt & ~hsk_q & ~phy_q;
      hsk_done_q <= done_evt & hsk_q;
      phy_done_q <= (done_evt & phy_q) | nopid_done;
    end
  end

  // CRC restarts on every PID and sees only data bytes
  assign crc_clear_o = (state_q == TX_XPID);
  assign crc_step_o  = s_fire & s_beat_i.keep;
  assign crc_byte_o  = s_beat_i.data;

  assign encode_idle_o = (state_q == TX_IDLE);
  assign usb_busy_o    = (state_q != TX_IDLE);
  assign phy_busy_o    = (state_q != TX_IDLE) && (state_q != TX_DONE);
  assign usb_done_o    = usb_done_q;
  assign hsk_done_o    = hsk_done_q;
  assign phy_done_o    = phy_done_q;

endmodule

`default_nettype wire

/* ulpi_skid_loader.sv */
`timescale 1ns/10ps
`default_nettype none

// Two-entry output register in front of the ULPI pins
// Head entry drives the bus, temp entry catches the byte in flight
// Temp entry can also be loaded directly for two-byte sequences
module ulpi_skid_loader
  import ulpi_tx_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  // Normal source path
  input  wire              s_valid_i,
  input  wire ulpi_beat_t  s_beat_i,
  output logic             s_ready_o,
  // Direct load of the temp entry
  input  wire              t_valid_i,
  input  wire ulpi_beat_t  t_beat_i,
  output logic             t_ready_o,
  // Head towards the PHY, ready is NXT
  output logic             m_valid_o,
  output ulpi_beat_t       m_beat_o,
  input  wire              m_ready_i,
  // ULPI pins
  output byte_t            ulpi_data_o,
  output logic             ulpi_stp_o
);

  logic       head_v;
  logic       tmp_v;
  ulpi_beat_t head_q;
  ulpi_beat_t tmp_q;

  logic head_pop;
  logic head_free;
  logic s_fire;
  logic t_fire;

  // A last beat is STP and leaves after one cycle, NXT or not
  assign head_pop  = head_v & (m_ready_i | head_q.last);
  assign head_free = ~head_v | head_pop;

  // Source is taken while the temp entry is free
  assign s_ready_o = ~tmp_v;
  // Direct load only into an empty buffer, so a paired source beat lands in head
  assign t_ready_o = ~head_v & ~tmp_v;

  assign s_fire = s_valid_i & s_ready_o;
  assign t_fire = t_valid_i & t_ready_o;

  // Occupancy, whole buffer empties after the STP cycle
  always_ff @(posedge clock) begin
    if (reset || (head_v && head_q.last)) begin
      head_v <= 1'b0;
      tmp_v  <= 1'b0;
    end else begin
      if (head_free) begin
        head_v <= tmp_v | s_fire;
      end
      if (t_fire) begin
        tmp_v <= 1'b1;
      end else if (s_fire && !head_free) begin
        // Head is stuck on NXT, park the new byte
        tmp_v <= 1'b1;
      end else if (head_free) begin
        // Parked byte moves up into head
        tmp_v <= 1'b0;
      end
    end
  end

  // Payload, temp entry has priority over the source when head frees up
  always_ff @(posedge clock) begin
    if (head_free) begin
      head_q <= tmp_v ? tmp_q : s_beat_i;
    end
    if (t_fire) begin
      tmp_q <= t_beat_i;
    end else if (s_fire && !head_free) begin
      tmp_q <= s_beat_i;
    end
  end

  assign m_valid_o = head_v;
  assign m_beat_o  = head_q;

  // Bus is zero while idle and during STP
  assign ulpi_stp_o  = head_v & head_q.last;
  assign ulpi_data_o = (head_v && !head_q.last) ? head_q.data : 8'h00;

endmodule

`default_nettype wire

/* ulpi_tx_checker.sv */
`timescale 1ns/10ps
`default_nettype none

// Monitor for the ULPI transmit path
// Builds the expected bytes per test and compares them at the done pulse
module ulpi_tx_checker
  import ulpi_tx_pkg::*;
(
  input  wire         clock,
  input  wire         reset,
  // Test description from the stimulus table
  input  wire         start_i,
  input  wire [2:0]   kind_i,
  input  wire pid_t   pid_i,
  input  wire byte_t  cmd0_i,
  input  wire byte_t  cmd1_i,
  input  wire [3:0]   len_i,
  input  wire [63:0]  payload_i,
  input  wire [2:0]   done_exp_i,
  // DUT pins
  input  wire         ulpi_dir_i,
  input  wire         ulpi_nxt_i,
  input  wire         ulpi_stp_i,
  input  wire byte_t  ulpi_data_i,
  input  wire         head_valid_i,
  input  wire         encode_idle_i,
  input  wire         usb_busy_i,
  input  wire         phy_busy_i,
  input  wire         usb_done_i,
  input  wire         hsk_done_i,
  input  wire         phy_done_i,
  output int          pass_count_o,
  output int          fail_count_o
);

  localparam logic [2:0] KIND_PKT   = 3'd0;
  localparam logic [2:0] KIND_HSK   = 3'd1;
  localparam logic [2:0] KIND_REGW  = 3'd2;
  localparam logic [2:0] KIND_NOPID = 3'd3;

  byte_t      exp_q[$];
  byte_t      got_q[$];
  int         exp_stp;
  int         stp_seen;
  logic [2:0] exp_done;
  logic       armed;
  int         test_idx;
  int         cmp_passes;
  int         cmp_fails;
  int         dir_fails;
  int         busy_fails;
  logic       dir_q;
  logic       idle_hold;
  // Per-test observations of the bus and the busy flags
  logic       taken;
  logic       prev_stp;
  logic       prev_taken;
  logic       stp_data_bad;
  logic       phy_busy_seen;
  logic       tail_seen;

  assign pass_count_o = cmp_passes;
  assign fail_count_o = cmp_fails + dir_fails + busy_fails;

  // Reflected USB CRC16, shifting right with the mirrored polynomial
  function automatic crc16_t ref_crc(input logic [63:0] data, input int len);
    crc16_t rpoly;
    crc16_t r;
    rpoly = {<<{CRC16_POLY}};
    r = CRC16_INIT;
    for (int i = 0; i < len; i++) begin
      for (int b = 0; b < 8; b++) begin
        if (r[0] ^ data[8*i+b]) begin
          r = (r >> 1) ^ rpoly;
        end else begin
          r = r >> 1;
        end
      end
    end
    return ~r;
  endfunction

  task automatic build_expected();
    crc16_t crc;
    exp_q.delete();
    exp_stp = 1;
    case (kind_i)
      KIND_PKT: begin
        exp_q.push_back(TXCMD_NOPID | byte_t'(pid_i));
        for (int i = 0; i < int'(len_i); i++) begin
          exp_q.push_back(payload_i[8*i +: 8]);
        end
        // CRC goes out low byte first
        crc = ref_crc(payload_i, int'(len_i));
        exp_q.push_back(crc[7:0]);
        exp_q.push_back(crc[15:8]);
      end
      KIND_HSK: exp_q.push_back(TXCMD_NOPID | byte_t'(pid_i));
      KIND_REGW: begin
        exp_q.push_back(cmd0_i);
        exp_q.push_back(cmd1_i);
      end
      KIND_NOPID: begin
        // NOPID ends without STP
        exp_q.push_back(TXCMD_NOPID);
        exp_stp = 0;
      end
      default: begin
      end
    endcase
  endtask

  task automatic compare_result();
    string msg;
    msg = "";
    if (got_q.size() != exp_q.size()) begin
      msg = $sformatf("%0d bytes taken, %0d expected", got_q.size(), exp_q.size());
    end else begin
      for (int i = 0; i < got_q.size(); i++) begin
        if (msg == "" && got_q[i] != exp_q[i]) begin
          msg = $sformatf("byte %0d is %02h, expected %02h", i, got_q[i], exp_q[i]);
        end
      end
    end
    if (msg == "" && stp_seen != exp_stp) begin
      msg = $sformatf("%0d STP cycles, expected %0d", stp_seen, exp_stp);
    end
    if (msg == "" && stp_data_bad) begin
      msg = "data bus not zero during STP";
    end
    if (msg == "" && !phy_busy_seen) begin
      msg = "phy_busy_o never rose";
    end
    // Closing stage is still busy for USB but no longer for PHY commands
    if (msg == "" && exp_stp != 0 && !tail_seen) begin
      msg = "no cycle with usb_busy_o high and phy_busy_o low";
    end
    if (msg == "" && exp_stp != 0 && !prev_stp) begin
      msg = "done pulse not in the cycle after STP";
    end
    if (msg == "" && exp_stp == 0 && !prev_taken) begin
      msg = "done pulse not in the cycle after the byte was taken";
    end
    if (msg == "" && {phy_done_i, hsk_done_i, usb_done_i} != exp_done) begin
      msg = $sformatf("done pulse %03b, expected %03b",
                      {phy_done_i, hsk_done_i, usb_done_i}, exp_done);
    end
    if (msg == "") begin
      cmp_passes++;
      $display("PASS test %0d, %0d bytes", test_idx, got_q.size());
    end else begin
      cmp_fails++;
      $display("FAIL at %0t: test %0d, %s", $time, test_idx, msg);
    end
  endtask

  // Byte capture and compare
  always @(posedge clock) begin
    if (reset) begin
      armed = 1'b0;
      test_idx = 0;
      cmp_passes = 0;
      cmp_fails = 0;
      stp_seen = 0;
      prev_stp = 1'b0;
      prev_taken = 1'b0;
      stp_data_bad = 1'b0;
      phy_busy_seen = 1'b0;
      tail_seen = 1'b0;
      got_q.delete();
    end else if (start_i) begin
      build_expected();
      exp_done = done_exp_i;
      got_q.delete();
      stp_seen = 0;
      prev_stp = 1'b0;
      prev_taken = 1'b0;
      stp_data_bad = 1'b0;
      phy_busy_seen = 1'b0;
      tail_seen = 1'b0;
      armed = 1'b1;
    end else begin
      // A byte counts only when a real head sits on the bus
      taken = head_valid_i && ulpi_nxt_i && !ulpi_stp_i;
      if (taken) begin
        got_q.push_back(ulpi_data_i);
      end
      if (ulpi_stp_i) begin
        stp_seen++;
        if (ulpi_data_i != 8'h00) begin
          stp_data_bad = 1'b1;
        end
      end
      if (phy_busy_i) begin
        phy_busy_seen = 1'b1;
      end
      if (usb_busy_i && !phy_busy_i) begin
        tail_seen = 1'b1;
      end
      if (usb_done_i || hsk_done_i || phy_done_i) begin
        if (!armed) begin
          cmp_fails++;
          $display("Unexpected done pulse at %0t with no test running", $time);
        end else begin
          compare_result();
          armed = 1'b0;
          test_idx++;
        end
      end
      prev_stp = ulpi_stp_i;
      prev_taken = taken;
    end
  end

  // Idle must hold across DIR and the turnaround cycle
  always @(posedge clock) begin
    if (reset) begin
      dir_q     <= 1'b0;
      idle_hold <= 1'b0;
      dir_fails <= 0;
    end else begin
      if (idle_hold && !encode_idle_i) begin
        dir_fails <= dir_fails + 1;
        $display("FAIL at %0t: encoder left idle while DIR owned the bus", $time);
      end
      idle_hold <= (ulpi_dir_i || dir_q) && encode_idle_i;
      dir_q     <= ulpi_dir_i;
    end
  end

  // usb_busy is the inverse of idle, phy_busy never shows while idle
  always @(posedge clock) begin
    if (reset) begin
      busy_fails <= 0;
    end else if (usb_busy_i == encode_idle_i || (phy_busy_i && encode_idle_i)) begin
      busy_fails <= busy_fails + 1;
      $display("FAIL at %0t: usb_busy %b, phy_busy %b with idle %b",
               $time, usb_busy_i, phy_busy_i, encode_idle_i);
    end
  end

endmodule

`default_nettype wire

/* ulpi_tx_pkg.sv */
`default_nettype none

// Shared types and constants for the ULPI transmit path
package ulpi_tx_pkg;

  // One byte on the ULPI data bus
  typedef logic [7:0] byte_t;

  // USB CRC16 remainder
  typedef logic [15:0] crc16_t;

  // USB packet identifier, the low nibble of a TXCMD
  typedef logic [3:0] pid_t;

  // One byte headed for the PHY
  // last means STP goes out in place of this byte
  typedef struct packed {
    byte_t data;
    logic  last;
  } ulpi_beat_t;

  // One byte of the link-side packet stream
  // keep low marks an end of packet with no data byte
  typedef struct packed {
    byte_t data;
    logic  keep;
    logic  last;
  } usb_beat_t;

  // Encoder states, one-hot
  typedef enum logic [9:0] {
    TX_IDLE = 10'h001,
    TX_XPID = 10'h002,
    TX_DATA = 10'h004,
    TX_CRC0 = 10'h008,
    TX_CRC1 = 10'h010,
    TX_LAST = 10'h020,
    TX_DONE = 10'h040,
    TX_INIT = 10'h080,
    TX_REGW = 10'h100,
    TX_STOP = 10'h200
  } tx_state_e;

  // Transmit command without PID
  // Also the prefix that is ORed with the PID nibble
  localparam byte_t TXCMD_NOPID = 8'h40;

  // Beat that turns into a single STP cycle
  localparam ulpi_beat_t STOP_BEAT = '{data: 8'h00, last: 1'b1};

  // USB CRC16 seed
  localparam crc16_t CRC16_INIT = 16'hFFFF;

  // x^16 + x^15 + x^2 + 1, fed LSB first
  localparam crc16_t CRC16_POLY = 16'h8005;

endpackage

`default_nettype wire

/* ulpi_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

// ULPI link transmitter, encoder plus CRC plus output buffer
module ulpi_tx_top
  import ulpi_tx_pkg::*;
(
  input  wire             clock,
  input  wire             reset,
  input  wire             high_speed_i,
  input  wire             s_valid_i,
  input  wire usb_beat_t  s_beat_i,
  input  wire pid_t       s_pid_i,
  output logic            s_ready_o,
  input  wire             phy_write_i,
  input  wire             phy_nopid_i,
  input  wire             phy_stop_i,
  input  wire byte_t      phy_addr_i,
  input  wire byte_t      phy_data_i,
  input  wire             hsk_send_i,
  output logic            encode_idle_o,
  output logic            usb_busy_o,
  output logic            usb_done_o,
  output logic            phy_busy_o,
  output logic            phy_done_o,
  output logic            hsk_done_o,
  input  wire             ulpi_dir_i,
  input  wire             ulpi_nxt_i,
  output logic            ulpi_stp_o,
  output byte_t           ulpi_data_o
);

  logic       src_valid;
  logic       src_ready;
  ulpi_beat_t src_beat;
  logic       tmp_valid;
  logic       tmp_ready;
  ulpi_beat_t tmp_beat;
  logic       head_valid;
  ulpi_beat_t head_beat;
  logic       head_taken;
  logic       head_last;
  logic       crc_clear;
  logic       crc_step;
  byte_t      crc_byte;
  crc16_t     crc;

  // NXT takes the byte on the bus, a last head is the STP cycle
  assign head_taken = head_valid & ulpi_nxt_i;
  assign head_last  = head_valid & head_beat.last;

  ulpi_encoder u_encoder (
    .clock         (clock),
    .reset         (reset),
    .high_speed_i  (high_speed_i),
    .s_valid_i     (s_valid_i),
    .s_beat_i      (s_beat_i),
    .s_pid_i       (s_pid_i),
    .s_ready_o     (s_ready_o),
    .phy_write_i   (phy_write_i),
    .phy_nopid_i   (phy_nopid_i),
    .phy_stop_i    (phy_stop_i),
    .phy_addr_i    (phy_addr_i),
    .phy_data_i    (phy_data_i),
    .hsk_send_i    (hsk_send_i),
    .ulpi_dir_i    (ulpi_dir_i),
    .encode_idle_o (encode_idle_o),
    .usb_busy_o    (usb_busy_o),
    .usb_done_o    (usb_done_o),
    .phy_busy_o    (phy_busy_o),
    .phy_done_o    (phy_done_o),
    .hsk_done_o    (hsk_done_o),
    .crc_i         (crc),
    .crc_clear_o   (crc_clear),
    .crc_step_o    (crc_step),
    .crc_byte_o    (crc_byte),
    .src_ready_i   (src_ready),
    .tmp_ready_i   (tmp_ready),
    .head_valid_i  (head_valid),
    .head_taken_i  (head_taken),
    .head_last_i   (head_last),
    .src_valid_o   (src_valid),
    .src_beat_o    (src_beat),
    .tmp_valid_o   (tmp_valid),
    .tmp_beat_o    (tmp_beat)
  );

  usb_crc16 u_crc16 (
    .clock   (clock),
    .reset   (reset),
    .clear_i (crc_clear),
    .step_i  (crc_step),
    .byte_i  (crc_byte),
    .crc_o   (crc)
  );

  ulpi_skid_loader u_skid (
    .clock       (clock),
    .reset       (reset),
    .s_valid_i   (src_valid),
    .s_beat_i    (src_beat),
    .s_ready_o   (src_ready),
    .t_valid_i   (tmp_valid),
    .t_beat_i    (tmp_beat),
    .t_ready_o   (tmp_ready),
    .m_valid_o   (head_valid),
    .m_beat_o    (head_beat),
    .m_ready_i   (ulpi_nxt_i),
    .ulpi_data_o (ulpi_data_o),
    .ulpi_stp_o  (ulpi_stp_o)
  );

endmodule

`default_nettype wire

/* usb_crc16.sv */
`timescale 1ns/10ps
`default_nettype none

// Running USB CRC16 over the payload bytes of one packet
module usb_crc16
  import ulpi_tx_pkg::*;
(
  input  wire         clock,
  input  wire         reset,
  input  wire         clear_i,
  input  wire         step_i,
  input  wire byte_t  byte_i,
  output crc16_t      crc_o
);

  crc16_t crc_q;

  // Advance the remainder by eight bits, bit 0 of the byte first
  // Remainder is kept MSB-first, so the feedback tap is bit 15
  function automatic crc16_t crc16_byte(input crc16_t crc, input byte_t data);
    crc16_t c;
    logic   fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ CRC16_POLY;
      end
    end
    return c;
  endfunction

  // Clear wins over step, the encoder never asks for both
  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= CRC16_INIT;
    end else if (step_i) begin
      crc_q <= crc16_byte(crc_q, byte_i);
    end
  end

  // Wire value is the complement, bit-reversed
  // Low byte of crc_o goes out first
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_o[i] = ~crc_q[15-i];
    end
  end

endmodule

`default_nettype wire
